/* thor_decode.f */
+incdir+source
source/thor_decode_pkg.sv
source/thor_decode_cfg.sv
source/thor_decode_rt.sv
source/thor_decode_rs.sv
source/thor_decode_stage.sv
bench/thor_decode_checker.sv
bench/thor_decode_tb.sv

/* bench/thor_decode_tb.sv */
// ====================
// Thor decode stage testbench
// Directed table and random ADDI words checked against the register map
// ====================
`timescale 1ns/1ps
`include "thor_decode_defines.svh"

module thor_decode_tb;

	typedef struct packed {
		thor_decode_pkg::isn_u isn;
		logic [1:0] en;	// Bit 0 FP and bit 1 vector
		thor_decode_pkg::reg_num_t rt;
		thor_decode_pkg::reg_num_t ra;
		thor_decode_pkg::reg_num_t rb;
		logic ill;
	} row_t;

	logic clk;
	logic arst_n;
	logic isn_valid;
	thor_decode_pkg::isn_u isn;
	logic cfg_we;
	logic [1:0] cfg_wdata;
	logic dec_valid;
	thor_decode_pkg::reg_num_t rt;
	thor_decode_pkg::reg_num_t ra;
	thor_decode_pkg::reg_num_t rb;
	logic illegal;

	row_t tbl[$];	// Directed rows
	row_t held;	// Expected output register
	logic exp_valid;
	logic [1:0] cur_en;	// Enables now in the DUT
	bit table_built;

	thor_decode_stage dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	// ====================
	// Word builders
	// ====================
	function automatic thor_decode_pkg::isn_u gen_word(input logic [6:0] op,
		input logic [4:0] f_rt, f_ra, f_rb, input logic [2:0] fmt, input logic [3:0] func);
		thor_decode_pkg::isn_u w;
		w = '0;
		w.gen.upper = 32'h5a5a_0f0f;	// Not part of the decode
		w.gen.opcode = thor_decode_pkg::opcode_e'(op);
		w.gen.fmt = fmt;
		w.gen.func = func;
		w.gen.rt = f_rt;
		w.gen.ra = f_ra;
		w.gen.rb = f_rb;
		return w;
	endfunction

	function automatic thor_decode_pkg::isn_u flt_word(input logic [3:0] func,
		input logic [4:0] f_rt, f_ra, f_rb);
		return gen_word(thor_decode_pkg::OP_FLT2, f_rt, f_ra, f_rb, 3'b000, func);
	endfunction

	function automatic thor_decode_pkg::isn_u br_word(input logic [6:0] op,
		input logic [2:0] lk, input logic [4:0] f_ra, f_rb);
		thor_decode_pkg::isn_u w;
		w = '0;
		w.br.opcode = thor_decode_pkg::opcode_e'(op);
		{w.br.lk_hi, w.br.lk_lo} = lk;	// Bits 7 and 9:8
		w.br.cnd = 2'b01;
		w.br.ra = f_ra;
		w.br.rb = f_rb;
		w.br.disp = 42'h2_0345;
		return w;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// ====================
	// Checks
	// ====================
	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_reg(input string name, input thor_decode_pkg::reg_num_t got,
		input thor_decode_pkg::reg_num_t want);
		if (got !== want)
			fail_stop($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, want));
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want)
			fail_stop($sformatf("ERR %0t %s got %b expected %b", $time, name, got, want));
	endtask

	// Check the last edge and drive the next one
	task automatic step(input logic v, input row_t r, input logic we, input logic [1:0] wd);
		@(negedge clk);
		check_bit("dec_valid", dec_valid, exp_valid);
		check_bit("illegal", illegal, held.ill);
		check_reg("rt", rt, held.rt);
		check_reg("ra", ra, held.ra);
		check_reg("rb", rb, held.rb);
		isn_valid = v;
		isn = r.isn;
		cfg_we = we;
		cfg_wdata = wd;
		exp_valid = v;
		if (v)
			held = r;	// Outputs hold between strobes
	endtask

	task automatic apply_row(input row_t r);
		if (r.en != cur_en)
		begin
			step(1'b0, r, 1'b1, r.en);	// Enable write cycle
			cur_en = r.en;
		end
		step(1'b1, r, 1'b0, 2'b00);
	endtask

	task automatic add_row(input thor_decode_pkg::isn_u w, input logic [1:0] en,
		input int e_rt, input int e_ra, input int e_rb, input logic ill);
		row_t r;
		r.isn = w;
		r.en = en;
		r.rt = thor_decode_pkg::reg_num_t'(e_rt);
		r.ra = thor_decode_pkg::reg_num_t'(e_ra);
		r.rb = thor_decode_pkg::reg_num_t'(e_rb);
		r.ill = ill;
		tbl.push_back(r);
	endtask

	// ====================
	// Directed table
	// ====================
	task automatic build_table();
		add_row(gen_word(thor_decode_pkg::OP_ADDI, 5, 3, 9, 0, 0), 2'b11, 5, 3, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_ADDI, 7, 2, 0, 3'b010, 0), 2'b11, 103, 98, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_R2, 1, 2, 3, 0, 0), 2'b11, 1, 2, 3, 0);
		add_row(gen_word(thor_decode_pkg::OP_R2, 1, 2, 3, 3'b110, 0), 2'b11, 97, 98, 99, 0);
		add_row(gen_word(thor_decode_pkg::OP_MOV, 3, 0, 2, 0, 0), 2'b11, 67, 0, 0, 0);
		add_row(flt_word(thor_decode_pkg::FADD, 2, 4, 5), 2'b11, 66, 68, 69, 0);
		add_row(flt_word(thor_decode_pkg::FMUL, 31, 0, 1), 2'b11, 95, 64, 65, 0);
		add_row(flt_word(thor_decode_pkg::FCMP, 9, 1, 2), 2'b11, 9, 65, 66, 0);
		add_row(flt_word(thor_decode_pkg::FSEQ, 19, 3, 4), 2'b11, 35, 67, 68, 0);	// PR 32+3
		add_row(flt_word(4'h0, 3, 1, 1), 2'b11, 0, 65, 65, 0);
		add_row(gen_word(thor_decode_pkg::OP_FLDS, 6, 10, 0, 0, 0), 2'b11, 70, 10, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_FLDD, 6, 10, 0, 3'b100, 0), 2'b11, 102, 10, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_LDO, 8, 11, 0, 0, 0), 2'b11, 8, 11, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_LDB, 8, 11, 0, 3'b100, 0), 2'b11, 104, 11, 0, 0);
		add_row(br_word(thor_decode_pkg::OP_BEQ, 3'b000, 4, 5), 2'b11, 0, 4, 5, 0);
		add_row(br_word(thor_decode_pkg::OP_BNE, 3'b101, 6, 7), 2'b11, 48, 6, 7, 0);
		add_row(br_word(thor_decode_pkg::OP_BLT, 3'b110, 1, 2), 2'b11, 49, 1, 2, 0);
		add_row(br_word(thor_decode_pkg::OP_BGE, 3'b111, 30, 31), 2'b11, 50, 30, 31, 0);
		add_row(br_word(thor_decode_pkg::OP_JSR, 3'b101, 3, 4), 2'b11, 48, 0, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_RTX, 8, 0, 0, 0, 0), 2'b11, 31, 0, 0, 0);	// RTD
		add_row(gen_word(thor_decode_pkg::OP_RTX, 4, 0, 0, 0, 0), 2'b11, 0, 0, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_STB, 7, 5, 6, 0, 0), 2'b11, 0, 5, 6, 0);
		add_row(gen_word(thor_decode_pkg::OP_NOP, 5, 3, 2, 0, 0), 2'b11, 0, 0, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_PRFILL, 31, 0, 0, 0, 0), 2'b11, 47, 0, 0, 0);
		add_row(gen_word(7'h7f, 5, 1, 2, 0, 0), 2'b11, 0, 0, 0, 0);	// Unknown opcode
		// Unit enables off and back on
		add_row(flt_word(thor_decode_pkg::FADD, 2, 4, 5), 2'b10, 0, 68, 69, 1);
		add_row(gen_word(thor_decode_pkg::OP_ADDI, 7, 2, 0, 3'b010, 0), 2'b10, 103, 98, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_ADDI, 7, 2, 0, 3'b010, 0), 2'b01, 0, 98, 0, 1);
		add_row(gen_word(thor_decode_pkg::OP_FLDS, 6, 10, 0, 0, 0), 2'b01, 70, 10, 0, 0);
		add_row(gen_word(thor_decode_pkg::OP_MOV, 3, 0, 3, 0, 0), 2'b00, 0, 0, 0, 1);
		add_row(gen_word(thor_decode_pkg::OP_FLDD, 6, 10, 0, 3'b100, 0), 2'b00, 0, 10, 0, 1);
		add_row(flt_word(thor_decode_pkg::FADD, 2, 4, 5), 2'b11, 66, 68, 69, 0);
		add_row(gen_word(thor_decode_pkg::OP_ADDI, 7, 2, 0, 3'b010, 0), 2'b11, 103, 98, 0, 0);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial
	begin
		row_t r;
		logic [31:0] seed;
		int vb;
		arst_n = 1'b0;
		isn_valid = 1'b0;
		isn = '0;
		cfg_we = 1'b0;
		cfg_wdata = 2'b11;
		held = '0;	// Outputs after reset
		exp_valid = 1'b0;
		cur_en = 2'b11;	// Both units on after reset
		build_table();
		table_built = 1'b1;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		foreach (tbl[i])
			apply_row(tbl[i]);
		// Random ADDI words with fmt 00x giving GPRs
		seed = 32'h22a99f2e;
		repeat (200)
		begin
			seed = xorshift(seed);
			vb = (seed[17:16] != 2'b00) ? `THOR_VR_BASE : 0;
			r = '0;
			r.isn = gen_word(thor_decode_pkg::OP_ADDI, seed[4:0], seed[9:5], seed[14:10],
				seed[17:15], seed[21:18]);
			r.en = 2'b11;
			r.rt = thor_decode_pkg::reg_num_t'(vb + seed[4:0]);
			r.ra = thor_decode_pkg::reg_num_t'(vb + seed[9:5]);
			apply_row(r);
		end
		step(1'b0, r, 1'b0, 2'b00);	// Last result
		step(1'b0, r, 1'b0, 2'b00);	// dec_valid low again
		if (dut0.chk0.fail_count == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
			fail_stop("Checker assertions failed during the run");
	end

	// Stop at the first checker assertion failure
	always @(dut0.chk0.fail_count)
		if (dut0.chk0.fail_count != 0)
			fail_stop("A checker assertion failed");

	// Watchdog
	initial
	begin
		int limit;
		wait (table_built);
		limit = tbl.size() + 200 + 20;
		repeat (limit) @(posedge clk);
		fail_stop($sformatf("Timeout, decode tests still running after %0d cycles", limit));
	end

endmodule

/* bench/thor_decode_checker.sv */
// ====================
// Thor decode stage checker
// Reset state, strobe latency and the trap target rule
// ====================
`timescale 1ns/1ps

module thor_decode_checker
(
	input logic clk,
	input logic arst_n,
	input logic isn_valid,
	input logic dec_valid,
	input thor_decode_pkg::reg_num_t rt,
	input logic illegal
);

	int unsigned fail_count;	// Assertion failures so far

	initial
		fail_count = 0;

	// One cycle from strobe to result
	a_valid_lat: assert property (@(posedge clk) disable iff (!arst_n)
		dec_valid == $past(isn_valid))
	else
	begin
		fail_count++;
		$error("dec_valid does not follow isn_valid by one cycle");
	end

	a_trap_rt: assert property (@(posedge clk) disable iff (!arst_n)
		illegal |-> (rt == '0))	// Trapped word writes nothing
	else
	begin
		fail_count++;
		$error("illegal is set with a nonzero rt");
	end

	a_reset: assert property (@(posedge clk) !arst_n |-> (!dec_valid && !illegal))
	else
	begin
		fail_count++;
		$error("dec_valid or illegal high during reset");
	end

endmodule

bind thor_decode_stage thor_decode_checker chk0
(
	.clk(clk),
	.arst_n(arst_n),
	.isn_valid(isn_valid),
	.dec_valid(dec_valid),
	.rt(rt),
	.illegal(illegal)
);

/* source/thor_decode_stage.sv */
// ====================
// Thor register decode stage
// Captures one instruction per clock, decodes Rt, Ra, Rb and the
// unit-enable trap, one cycle of latency
// ====================
`timescale 1ns/1ps

module thor_decode_stage
(
	input logic clk,
	input logic arst_n,
	input logic isn_valid,	// Strobe with isn
	input thor_decode_pkg::isn_u isn,
	input logic cfg_we,	// Strobe with cfg_wdata
	input logic [1:0] cfg_wdata,
	output logic dec_valid,
	output thor_decode_pkg::reg_num_t rt,
	output thor_decode_pkg::reg_num_t ra,
	output thor_decode_pkg::reg_num_t rb,
	output logic illegal
);

	logic fp_en;
	logic vec_en;
	thor_decode_pkg::reg_num_t rt_d;	// Decoder outputs
	thor_decode_pkg::reg_num_t ra_d;
	thor_decode_pkg::reg_num_t rb_d;
	logic illegal_d;

	// ====================
	// Configuration and decoders
	// ====================
	thor_decode_cfg cfg0
	(
		.clk(clk),
		.arst_n(arst_n),
		.cfg_we(cfg_we),
		.cfg_wdata(cfg_wdata),
		.fp_en(fp_en),
		.vec_en(vec_en)
	);

	thor_decode_rt rt0
	(
		.isn(isn),
		.fp_en(fp_en),	// Enables from before this edge
		.vec_en(vec_en),
		.rt(rt_d),
		.illegal(illegal_d)
	);

	thor_decode_rs rs0
	(
		.isn(isn),
		.ra(ra_d),
		.rb(rb_d)
	);

	// ====================
	// Capture register
	// ====================

	// Instruction decoded as it arrives, results held until the next strobe
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dec_valid <= 1'b0;
			rt <= '0;
			ra <= '0;
			rb <= '0;
			illegal <= 1'b0;
		end
		else
		begin
			dec_valid <= isn_valid;	// One cycle behind
			if (isn_valid)
			begin
				rt <= rt_d;
				ra <= ra_d;
				rb <= rb_d;
				illegal <= illegal_d;
			end
		end
	end

endmodule

/* source/thor_decode_rs.sv */
// ====================
// Thor source register decode
// Finds the unified Ra and Rb numbers
// ====================
`timescale 1ns/1ps
`include "thor_decode_defines.svh"

module thor_decode_rs
(
	input thor_decode_pkg::isn_u isn,
	output thor_decode_pkg::reg_num_t ra,
	output thor_decode_pkg::reg_num_t rb
);

	logic vec_fmt;	// fmt not 00x

	assign vec_fmt = (isn.gen.fmt[2:1] != 2'b00);

	always_comb
	begin
		ra = '0;
		rb = '0;
		case (isn.gen.opcode)
		thor_decode_pkg::OP_ADDI:
			// Immediate takes the Rb slot
			ra = vec_fmt ? thor_decode_pkg::reg_num_t'(`THOR_VR_BASE + isn.gen.ra)
				: thor_decode_pkg::reg_num_t'(isn.gen.ra);
		thor_decode_pkg::OP_R2:
		begin
			// Same class as Rt
			ra = vec_fmt ? thor_decode_pkg::reg_num_t'(`THOR_VR_BASE + isn.gen.ra)
				: thor_decode_pkg::reg_num_t'(isn.gen.ra);
			rb = vec_fmt ? thor_decode_pkg::reg_num_t'(`THOR_VR_BASE + isn.gen.rb)
				: thor_decode_pkg::reg_num_t'(isn.gen.rb);
		end
		thor_decode_pkg::OP_FLT2:
		begin
			ra = thor_decode_pkg::reg_num_t'(`THOR_FPR_BASE + isn.gen.ra);	// Fa
			rb = thor_decode_pkg::reg_num_t'(`THOR_FPR_BASE + isn.gen.rb);	// Fb
		end
		thor_decode_pkg::OP_LDB,
		thor_decode_pkg::OP_LDW,
		thor_decode_pkg::OP_LDO,
		thor_decode_pkg::OP_FLDS,
		thor_decode_pkg::OP_FLDD:
			ra = thor_decode_pkg::reg_num_t'(isn.gen.ra);	// Base
		thor_decode_pkg::OP_STB,
		thor_decode_pkg::OP_STW,
		thor_decode_pkg::OP_STO:
		begin
			ra = thor_decode_pkg::reg_num_t'(isn.gen.ra);	// Base
			rb = thor_decode_pkg::reg_num_t'(isn.gen.rb);	// Store data
		end
		thor_decode_pkg::OP_BEQ,
		thor_decode_pkg::OP_BNE,
		thor_decode_pkg::OP_BLT,
		thor_decode_pkg::OP_BGE:
		begin
			// Compare operands, branch view
			ra = thor_decode_pkg::reg_num_t'(isn.br.ra);
			rb = thor_decode_pkg::reg_num_t'(isn.br.rb);
		end
		default:
		begin
			ra = '0;
			rb = '0;
		end
		endcase
	end

endmodule

/* source/thor_decode_rt.sv */
// ====================
// Thor target register decode
// Finds the unified Rt number and flags targets in disabled units
// ====================
`timescale 1ns/1ps
`include "thor_decode_defines.svh"

module thor_decode_rt
(
	input thor_decode_pkg::isn_u isn,
	input logic fp_en,
	input logic vec_en,
	output thor_decode_pkg::reg_num_t rt,
	output logic illegal
);

	thor_decode_pkg::reg_num_t rt_raw;	// Before the enable check
	thor_decode_pkg::reg_num_t rt_gpr;
	thor_decode_pkg::reg_num_t rt_fpr;
	thor_decode_pkg::reg_num_t rt_vr;
	thor_decode_pkg::reg_num_t rt_pr;
	logic fp_class;
	logic vec_class;

	// Rt field placed in each class
	assign rt_gpr = thor_decode_pkg::reg_num_t'(isn.gen.rt);
	assign rt_fpr = thor_decode_pkg::reg_num_t'(`THOR_FPR_BASE) + rt_gpr;
	assign rt_vr = thor_decode_pkg::reg_num_t'(`THOR_VR_BASE) + rt_gpr;
	assign rt_pr = thor_decode_pkg::reg_num_t'(`THOR_PR_BASE)
		+ thor_decode_pkg::reg_num_t'(isn.gen.rt[3:0]);	// Only 16 PRs

	// ====================
	// Opcode decode
	// ====================
	always_comb
	begin
		rt_raw = '0;
		case (isn.gen.opcode)
		thor_decode_pkg::OP_ADDI,
		thor_decode_pkg::OP_R2:
			if (isn.gen.fmt[2:1] == 2'b00)
				rt_raw = rt_gpr;	// Scalar
			else
				rt_raw = rt_vr;
		thor_decode_pkg::OP_MOV:
			rt_raw = {isn.gen.rb[1:0], isn.gen.rt};	// Class in bits 18:17
		thor_decode_pkg::OP_FLT2:
			case (thor_decode_pkg::flt_func_e'(isn.gen.func))
			thor_decode_pkg::FADD,
			thor_decode_pkg::FMUL:	rt_raw = rt_fpr;
			thor_decode_pkg::FCMP:	rt_raw = rt_gpr;	// Compare result
			thor_decode_pkg::FSEQ:	rt_raw = rt_pr;
			default:	rt_raw = '0;
			endcase
		thor_decode_pkg::OP_BEQ,
		thor_decode_pkg::OP_BNE,
		thor_decode_pkg::OP_BLT,
		thor_decode_pkg::OP_BGE,
		thor_decode_pkg::OP_JSR:
			// Link select from the branch view
			case ({isn.br.lk_hi, isn.br.lk_lo})
			3'b101:	rt_raw = thor_decode_pkg::reg_num_t'(`THOR_LR0);
			3'b110:	rt_raw = thor_decode_pkg::reg_num_t'(`THOR_LR0 + 1);
			3'b111:	rt_raw = thor_decode_pkg::reg_num_t'(`THOR_LR0 + 2);
			default:	rt_raw = '0;	// No link
			endcase
		thor_decode_pkg::OP_RTX:
			if (isn.gen.rt[3:2] == 2'b10)	// Bits 10:9, RTD
				rt_raw = thor_decode_pkg::reg_num_t'(`THOR_RTD_REG);
		thor_decode_pkg::OP_LDB,
		thor_decode_pkg::OP_LDW,
		thor_decode_pkg::OP_LDO:
			rt_raw = isn.gen.fmt[2] ? rt_vr : rt_gpr;	// Bit 31
		thor_decode_pkg::OP_FLDS,
		thor_decode_pkg::OP_FLDD:
			rt_raw = isn.gen.fmt[2] ? rt_vr : rt_fpr;
		thor_decode_pkg::OP_PRFILL:
			rt_raw = rt_pr;
		default:	// Stores, NOP, unknown
			rt_raw = '0;
		endcase
	end

	// ====================
	// Unit enable check
	// ====================

	// Top two bits give the class, 10 FPR and 11 VR
	assign fp_class = (rt_raw[`THOR_REG_W-1 -: 2] == 2'b10);
	assign vec_class = (rt_raw[`THOR_REG_W-1 -: 2] == 2'b11);

	assign illegal = (fp_class && !fp_en) || (vec_class && !vec_en);
	assign rt = illegal ? '0 : rt_raw;	// No write on a trap

endmodule

/* source/thor_decode_cfg.sv */
// ====================
// Thor decode unit enables
// FP and vector enable flops, loaded by a write strobe
// ====================
`timescale 1ns/1ps

module thor_decode_cfg
(
	input logic clk,
	input logic arst_n,
	input logic cfg_we,	// Write strobe
	input logic [1:0] cfg_wdata,	// Bit 0 FP, bit 1 vector
	output logic fp_en,
	output logic vec_en
);

	// ====================
	// Enable flops
	// ====================

	// Both units come up enabled
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fp_en <= 1'b1;
			vec_en <= 1'b1;
		end
		else if (cfg_we)
		begin
			fp_en <= cfg_wdata[0];	// FP unit
			vec_en <= cfg_wdata[1];	// Vector unit
		end
	end

	// New value seen by instructions
	// captured after the write edge

endmodule

/* source/thor_decode_pkg.sv */
// ====================
// Thor decode types
// Opcodes, FLT2 function codes, register number and the
// instruction word with its generic and branch views
// ====================
`include "thor_decode_defines.svh"

package thor_decode_pkg;

	typedef logic [`THOR_REG_W-1:0] reg_num_t;	// Unified register number

	// Opcode subset handled by the stage
	typedef enum logic [6:0] {
		OP_NOP    = 7'h00,
		OP_R2     = 7'h02,
		OP_ADDI   = 7'h04,
		OP_MOV    = 7'h0B,
		OP_FLT2   = 7'h0C,
		OP_PRFILL = 7'h0F,
		OP_JSR    = 7'h20,
		OP_RTX    = 7'h21,	// RTS / RTE / RTD
		OP_BEQ    = 7'h26,
		OP_BNE    = 7'h27,
		OP_BLT    = 7'h28,
		OP_BGE    = 7'h29,
		OP_LDB    = 7'h40,
		OP_LDW    = 7'h41,
		OP_LDO    = 7'h42,
		OP_FLDS   = 7'h44,
		OP_FLDD   = 7'h45,
		OP_STB    = 7'h50,
		OP_STW    = 7'h51,
		OP_STO    = 7'h52
	} opcode_e;

	// FLT2 function field, bits 25:22
	typedef enum logic [3:0] {
		FADD = 4'h4,
		FMUL = 4'h6,
		FCMP = 4'h8,	// Result to a GPR
		FSEQ = 4'hA	// Result to a predicate
	} flt_func_e;

	// Generic format
	typedef struct packed {
		logic [`THOR_ISN_W-33:0] upper;	// 63:32
		logic [2:0] fmt;	// 31:29, 00x selects GPRs
		logic [2:0] sz;	// 28:26
		logic [3:0] func;	// 25:22
		logic [4:0] rb;	// 21:17
		logic [4:0] ra;	// 16:12
		logic [4:0] rt;	// 11:7
		opcode_e opcode;	// 6:0
	} isn_gen_t;

	// Branch and JSR format
	typedef struct packed {
		logic [`THOR_ISN_W-23:0] disp;	// 63:22
		logic [4:0] rb;	// 21:17
		logic [4:0] ra;	// 16:12
		logic [1:0] cnd;	// 11:10
		logic [1:0] lk_lo;	// 9:8
		logic lk_hi;	// 7
		opcode_e opcode;	// 6:0
	} isn_br_t;

	// Same 64 bits, two decodes
	typedef union packed {
		isn_gen_t gen;
		isn_br_t br;
	} isn_u;

endpackage

/* source/thor_decode_defines.svh */
// ====================
// Thor decode constants
// Field widths and fixed register numbers of the unified register map
// ====================
`ifndef THOR_DECODE_DEFINES_SVH
`define THOR_DECODE_DEFINES_SVH

// Word and register widths
`define THOR_ISN_W	64	// Instruction word
`define THOR_REG_W	7	// Unified register number

// Register class bases
// 0..31 GPR, 32..47 PR, 48..50 LR, 64..95 FPR, 96..127 VR
`define THOR_PR_BASE	32	// Predicate registers
`define THOR_LR0	48	// First link register
`define THOR_FPR_BASE	64	// Float registers
`define THOR_VR_BASE	96	// Vector registers

// Fixed targets
`define THOR_RTD_REG	31	// Written by RTD

`endif
